// ==== bank_req_if.sv ====
`timescale 1ns/10ps

interface bank_req_if import dmem_pkg::*; ();

    logic                  valid;
    mem_op_e               op;
    mem_size_e             size;
    logic                  is_signed;
    logic [ROW_WIDTH-1:0]  row;
    logic [OFF_WIDTH-1:0]  byte_off;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  credit;     // one pulse per popped entry

    modport dispatch (
        output valid, op, size, is_signed, row, byte_off, wdata,
        input  credit
    );

    modport bank (
        input  valid, op, size, is_signed, row, byte_off, wdata,
        output credit
    );

endinterface

// ==== bank_rsp_if.sv ====
`timescale 1ns/10ps

interface bank_rsp_if import dmem_pkg::*; ();

    logic                  valid;
    logic [DATA_WIDTH-1:0] rdata;      // full word, lane pick happens in the merger
    mem_size_e             size;
    logic                  is_signed;
    logic [OFF_WIDTH-1:0]  byte_off;
    logic                  credit;     // one pulse per freed buffer entry

    modport bank (
        output valid, rdata, size, is_signed, byte_off,
        input  credit
    );

    modport merge (
        input  valid, rdata, size, is_signed, byte_off,
        output credit
    );

endinterface

// ==== dmem_checker.sv ====
`timescale 1ns/10ps

module dmem_checker import dmem_pkg::*; (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  req_valid_i,
    input mem_op_e               req_op_i,
    input logic                  req_ready_o,
    input logic                  rsp_valid_o,
    input logic [DATA_WIDTH-1:0] rsp_rdata_o,
    input logic                  rsp_ready_i
);

    logic                   load_acc;
    logic                   rsp_take;
    logic [ORD_CNT_WIDTH:0] pending_q;      // accepted loads not yet answered

    assign load_acc = req_valid_i & req_ready_o & (req_op_i == OP_LOAD);
    assign rsp_take = rsp_valid_o & rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            case ({load_acc, rsp_take})
                2'b10:   pending_q <= pending_q + 1'b1;
                2'b01:   pending_q <= pending_q - 1'b1;
                default: pending_q <= pending_q;
            endcase
        end
    end

    a_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rsp_valid_o)
        else $error("rsp_valid_o high while in reset");

    a_hold_until_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
        else $error("response changed or vanished before it was taken");

    a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> pending_q != '0)
        else $error("response without an earlier accepted load");

endmodule

bind dmem_top dmem_checker u_checker (.*);

// ==== dmem_pkg.sv ====
package dmem_pkg;

    localparam int NUM_BANKS      = 4;
    localparam int BANK_WORDS     = 256;
    localparam int ADDR_WIDTH     = 12;
    localparam int DATA_WIDTH     = 32;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int ROW_WIDTH      = 8;
    localparam int OFF_WIDTH      = 2;               // byte offset inside a word
    localparam int BYTES_PER_WORD = DATA_WIDTH / 8;

    localparam int REQ_CREDITS    = 4;               // bank request FIFO depth
    localparam int RSP_CREDITS    = 2;               // merger buffer depth per bank
    localparam int ORDER_DEPTH    = NUM_BANKS * (REQ_CREDITS + RSP_CREDITS);

    localparam int REQ_PTR_WIDTH  = 2;
    localparam int REQ_CNT_WIDTH  = 3;               // holds 0..REQ_CREDITS
    localparam int RSP_PTR_WIDTH  = 1;
    localparam int RSP_CNT_WIDTH  = 2;               // holds 0..RSP_CREDITS
    localparam int ORD_PTR_WIDTH  = 5;
    localparam int ORD_CNT_WIDTH  = 5;               // holds 0..ORDER_DEPTH

    typedef enum logic {OP_LOAD = 1'b0, OP_STORE = 1'b1} mem_op_e;
    typedef enum logic {SIZE_WORD = 1'b0, SIZE_BYTE = 1'b1} mem_size_e;

    // big-endian lane pick, offset 0 is the top byte
    function automatic logic [7:0] sel_byte(input logic [DATA_WIDTH-1:0] word,
                                            input logic [OFF_WIDTH-1:0] off);
        logic [DATA_WIDTH-1:0] shifted;
        shifted = word >> (8 * (BYTES_PER_WORD - 1 - int'(off)));
        return shifted[7:0];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] ext_byte(input logic [7:0] b,
                                                       input logic is_signed);
        logic fill;
        fill = is_signed & b[7];                     // replicate bit 7 only when signed
        return {{(DATA_WIDTH-8){fill}}, b};
    endfunction

endpackage

// ==== dmem_tb.sv ====
`timescale 1ns/10ps

module dmem_tb import dmem_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STREAM_LEN     = 40;

    typedef struct packed {
        mem_op_e               op;
        mem_size_e             size;
        logic                  sgn;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } req_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  req_valid_i;
    mem_op_e               req_op_i;
    mem_size_e             req_size_i;
    logic                  req_signed_i;
    logic [ADDR_WIDTH-1:0] req_addr_i;
    logic [DATA_WIDTH-1:0] req_wdata_i;
    logic                  req_ready_o;
    logic                  rsp_valid_o;
    logic [DATA_WIDTH-1:0] rsp_rdata_o;
    logic                  rsp_ready_i;

    logic [7:0]            ref_mem [2**ADDR_WIDTH];   // expected byte contents
    req_t                  req_q [$];
    logic [DATA_WIDTH-1:0] exp_q [$];                 // expected load data in request order
    logic                  collect_done;
    int                    ready_drops = 0;
    string                 cur_test;
    int                    num_tests;
    int                    num_failed;
    int                    num_checks;
    int                    num_errors;
    int                    errors_at_start;

    tb_clock_gen u_clk (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    dmem_top dut0 (.*);

    // counts cycles where a request waits on a bank without credit
    always @(negedge clk_i) begin
        if (req_valid_i && !req_ready_o) ready_drops <= ready_drops + 1;
    end

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = num_errors;
        num_tests++;
    endtask

    task automatic end_test();
        if (num_errors == errors_at_start) begin
            $display("test %s: passed", cur_test);
        end else begin
            num_failed++;
            $display("test %s: failed with %0d errors", cur_test, num_errors - errors_at_start);
        end
    endtask

    task automatic end_run(input logic failed);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 num_tests, num_failed, num_checks, num_errors);
        if (failed) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [7:0] row,
                                                        input logic [1:0] bank,
                                                        input logic [1:0] off);
        return {row, bank, off};                    // bank sits in bits 3:2
    endfunction

    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr, ~addr, addr[7:0]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic void ref_write(input mem_size_e size, input logic [ADDR_WIDTH-1:0] addr,
                                      input logic [DATA_WIDTH-1:0] wdata);
        logic [ADDR_WIDTH-3:0] w;
        w = addr[ADDR_WIDTH-1:2];
        if (size == SIZE_BYTE) begin
            ref_mem[addr] = wdata[7:0];             // always the low byte of wdata
        end else begin
            ref_mem[{w, 2'd0}] = wdata[31:24];      // offset 0 is the top byte
            ref_mem[{w, 2'd1}] = wdata[23:16];
            ref_mem[{w, 2'd2}] = wdata[15:8];
            ref_mem[{w, 2'd3}] = wdata[7:0];
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_load(input mem_size_e size,
                                                            input logic sgn,
                                                            input logic [ADDR_WIDTH-1:0] addr);
        logic [7:0]            b;
        logic [ADDR_WIDTH-3:0] w;
        b = ref_mem[addr];
        w = addr[ADDR_WIDTH-1:2];
        if (size == SIZE_WORD) begin
            return {ref_mem[{w, 2'd0}], ref_mem[{w, 2'd1}], ref_mem[{w, 2'd2}], ref_mem[{w, 2'd3}]};
        end
        return sgn ? {{(DATA_WIDTH-8){b[7]}}, b} : {{(DATA_WIDTH-8){1'b0}}, b};
    endfunction

    task automatic push_req(input mem_op_e op, input mem_size_e size, input logic sgn,
                            input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] wdata);
        req_q.push_back(req_t'{op, size, sgn, addr, wdata});
        if (op == OP_STORE) begin
            ref_write(size, addr, wdata);
        end else begin
            exp_q.push_back(expected_load(size, sgn, addr));
        end
    endtask

    task automatic issue_req(input req_t r);
        int   n;
        logic accepted;
        n = 0;
        accepted = 1'b0;
        req_valid_i  = 1'b1;
        req_op_i     = r.op;
        req_size_i   = r.size;
        req_signed_i = r.sgn;
        req_addr_i   = r.addr;
        req_wdata_i  = r.wdata;
        while (!accepted && n < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            accepted = req_ready_o;                 // transfer at the coming edge
            @(posedge clk_i);
            #1;
            n++;
        end
        req_valid_i = 1'b0;
        if (!accepted) begin
            $display("timeout: request to address %h was never accepted", r.addr);
            end_run(1'b1);
        end
    endtask

    task automatic collect_rsp(output logic [DATA_WIDTH-1:0] data);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        data = '0;
        while (!taken && n < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            if (rsp_valid_o && rsp_ready_i) begin
                taken = 1'b1;
                data = rsp_rdata_o;
            end
            @(posedge clk_i);
            #1;
            n++;
        end
        if (!taken) begin
            $display("timeout: expected load response never arrived");
            end_run(1'b1);
        end
    endtask

    task automatic drive_rsp_ready(input logic stall);
        int cyc;
        cyc = 0;
        while (stall && !collect_done && cyc < 4000) begin
            if (cyc < 60 || (cyc >= 80 && cyc < 140)) begin
                rsp_ready_i = 1'b0;                 // long stalls fill the merger
            end else if (cyc < 80) begin
                rsp_ready_i = 1'b1;
            end else begin
                rsp_ready_i = ($urandom % 3) != 0;
            end
            @(posedge clk_i);
            #1;
            cyc++;
        end
        rsp_ready_i = 1'b1;
    endtask

    task automatic check_no_extra();
        logic extra;
        extra = 1'b0;
        repeat (10) begin
            @(negedge clk_i);
            extra = extra | rsp_valid_o;
        end
        @(posedge clk_i);
        #1;
        check_bit("rsp_valid_o", extra, 1'b0);
    endtask

    task automatic run_batch(input logic stall);
        int                    n_rsp;
        req_t                  r;
        logic [DATA_WIDTH-1:0] got;
        n_rsp = exp_q.size();
        collect_done = 1'b0;
        fork
            begin
                while (req_q.size() > 0) begin
                    r = req_q.pop_front();
                    issue_req(r);
                end
            end
            begin
                for (int i = 0; i < n_rsp; i++) begin
                    collect_rsp(got);
                    check_word("rsp_rdata_o", got, exp_q.pop_front());
                end
                collect_done = 1'b1;
            end
            drive_rsp_ready(stall);
        join
        check_no_extra();
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n_i !== 1'b1 && n < 20) begin
            @(posedge clk_i);
            n++;
        end
        #1;
        if (rst_n_i !== 1'b1) begin
            $display("timeout: reset was never released");
            end_run(1'b1);
        end
    endtask

    task automatic after_reset();
        start_test("after_reset");
        for (int b = 0; b < NUM_BANKS; b++) begin
            req_addr_i = make_addr(8'(17 * b), 2'(b), 2'(b));
            @(negedge clk_i);
            check_bit("req_ready_o", req_ready_o, 1'b1);
            check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
            @(posedge clk_i);
            #1;
        end
        end_test();
    endtask

    task automatic word_access();
        logic [ADDR_WIDTH-1:0] addr [12];
        start_test("word_access");
        for (int i = 0; i < 12; i++) begin
            addr[i] = make_addr(8'(8'h40 + 5 * i), 2'(i % 4), 2'd0);
            push_req(OP_STORE, SIZE_WORD, 1'b0, addr[i], $urandom);
        end
        for (int i = 0; i < 12; i++) begin
            // offset bits must not matter for words
            push_req(OP_LOAD, SIZE_WORD, 1'b0, addr[i] | ADDR_WIDTH'(i % 4), '0);
        end
        run_batch(1'b0);
        end_test();
    endtask

    task automatic byte_lanes();
        logic [ADDR_WIDTH-1:0] wa;
        logic [ADDR_WIDTH-1:0] wb;
        start_test("byte_lanes");
        wa = make_addr(8'h88, 2'd0, 2'd0);
        wb = make_addr(8'h88, 2'd3, 2'd0);
        push_req(OP_STORE, SIZE_WORD, 1'b0, wa, 32'h1122_3344);
        push_req(OP_STORE, SIZE_WORD, 1'b0, wb, 32'h5566_7788);
        for (int k = 0; k < 4; k++) begin
            push_req(OP_STORE, SIZE_BYTE, 1'b0, wa | ADDR_WIDTH'(k), {24'hDEAD_BE, 8'(8'hB0 + k)});
        end
        push_req(OP_STORE, SIZE_BYTE, 1'b0, wb | 12'd1, 32'h0000_00A1);
        push_req(OP_STORE, SIZE_BYTE, 1'b0, wb | 12'd3, 32'hFFFF_FFA3);
        push_req(OP_LOAD, SIZE_WORD, 1'b0, wa, '0);
        push_req(OP_LOAD, SIZE_WORD, 1'b0, wb, '0);
        run_batch(1'b0);
        end_test();
    endtask

    task automatic byte_extend();
        logic [ADDR_WIDTH-1:0] base [2];
        start_test("byte_extend");
        base[0] = make_addr(8'h90, 2'd2, 2'd0);
        base[1] = make_addr(8'h91, 2'd1, 2'd0);
        push_req(OP_STORE, SIZE_WORD, 1'b0, base[0], 32'h7F80_01FE);
        push_req(OP_STORE, SIZE_WORD, 1'b0, base[1], 32'h80FF_7F00);
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 4; k++) begin
                push_req(OP_LOAD, SIZE_BYTE, 1'b0, base[w] | ADDR_WIDTH'(k), '0);
                push_req(OP_LOAD, SIZE_BYTE, 1'b1, base[w] | ADDR_WIDTH'(k), '0);
            end
        end
        run_batch(1'b0);
        end_test();
    endtask

    task automatic preload_rows();
        logic [ADDR_WIDTH-1:0] a;
        for (int row = 0; row < 16; row++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                a = make_addr(8'(row), 2'(b), 2'd0);
                push_req(OP_STORE, SIZE_WORD, 1'b0, a, fill_word(a));
            end
        end
        run_batch(1'b0);
    endtask

    task automatic run_stream(input string name, input logic stall);
        logic [ADDR_WIDTH-1:0]     a;
        logic [BANK_SEL_WIDTH-1:0] b;
        int                        drops_before;
        start_test(name);
        drops_before = ready_drops;
        for (int i = 0; i < STREAM_LEN; i++) begin
            // bank 0 gets about five loads in eight
            b = ($urandom % 2 == 0) ? 2'd0 : BANK_SEL_WIDTH'($urandom % NUM_BANKS);
            a = make_addr(8'($urandom % 16), b, 2'($urandom % 4));
            push_req(OP_LOAD, ($urandom % 2 == 0) ? SIZE_WORD : SIZE_BYTE,
                     1'($urandom % 2), a, '0);
        end
        run_batch(stall);
        if (stall) begin
            check_bit("req_ready_o low seen", ready_drops != drops_before, 1'b1);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h6974_6d14));
        req_valid_i  = 1'b0;
        req_op_i     = OP_LOAD;
        req_size_i   = SIZE_WORD;
        req_signed_i = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        rsp_ready_i  = 1'b1;
        collect_done = 1'b0;
        num_tests    = 0;
        num_failed   = 0;
        num_checks   = 0;
        num_errors   = 0;
        wait_reset();
        after_reset();
        word_access();
        byte_lanes();
        byte_extend();
        preload_rows();
        run_stream("stream_order", 1'b0);
        run_stream("back_pressure", 1'b1);
        end_run(num_errors != 0);
    end

endmodule

// ==== dmem_top.sv ====
`timescale 1ns/10ps

module dmem_top import dmem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  mem_op_e               req_op_i,
    input  mem_size_e             req_size_i,
    input  logic                  req_signed_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0] req_wdata_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output logic [DATA_WIDTH-1:0] rsp_rdata_o,
    input  logic                  rsp_ready_i
);

    logic                      ord_push;
    logic [BANK_SEL_WIDTH-1:0] ord_bank;

    bank_req_if req_if [NUM_BANKS] ();
    bank_rsp_if rsp_if [NUM_BANKS] ();

    req_dispatch u_dispatch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_size_i   (req_size_i),
        .req_signed_i (req_signed_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .bank_o       (req_if),
        .ord_push_o   (ord_push),
        .ord_bank_o   (ord_bank)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        mem_bank u_bank (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (req_if[g]),
            .rsp_o   (rsp_if[g])
        );
    end

    rsp_merge u_merge (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_i       (rsp_if),
        .ord_push_i  (ord_push),
        .ord_bank_i  (ord_bank),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

// ==== mem_bank.sv ====
`timescale 1ns/10ps

module mem_bank import dmem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    bank_req_if.bank req_i,
    bank_rsp_if.bank rsp_o
);

    typedef struct packed {
        mem_op_e               op;
        mem_size_e             size;
        logic                  is_signed;
        logic [ROW_WIDTH-1:0]  row;
        logic [OFF_WIDTH-1:0]  byte_off;
        logic [DATA_WIDTH-1:0] wdata;
    } req_entry_t;

    logic [7:0]               mem_q [BANK_WORDS*BYTES_PER_WORD];
    req_entry_t               fifo_q [REQ_CREDITS];
    req_entry_t               head;
    logic [REQ_PTR_WIDTH-1:0] wr_ptr_q;
    logic [REQ_PTR_WIDTH-1:0] rd_ptr_q;
    logic [REQ_CNT_WIDTH-1:0] cnt_q;
    logic [RSP_CNT_WIDTH-1:0] rsp_cred_q;
    logic                     pop;
    logic                     pop_load;

    logic                     rsp_valid_q;
    logic [DATA_WIDTH-1:0]    rdata_q;
    mem_size_e                size_q;
    logic                     signed_q;
    logic [OFF_WIDTH-1:0]     off_q;

    assign head     = fifo_q[rd_ptr_q];
    // stores never wait, loads need room in the merger
    assign pop      = (cnt_q != '0) & ((head.op == OP_STORE) | (rsp_cred_q != '0));
    assign pop_load = pop & (head.op == OP_LOAD);

    assign req_i.credit = pop;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            cnt_q      <= '0;
            rsp_cred_q <= RSP_CNT_WIDTH'(RSP_CREDITS);
        end else begin
            if (req_i.valid) wr_ptr_q <= wr_ptr_q + 1'b1;   // credits rule out overflow
            if (pop)         rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({req_i.valid, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            case ({rsp_o.credit, pop_load})
                2'b10:   rsp_cred_q <= rsp_cred_q + 1'b1;
                2'b01:   rsp_cred_q <= rsp_cred_q - 1'b1;
                default: rsp_cred_q <= rsp_cred_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            fifo_q[wr_ptr_q] <= '{op:        req_i.op,
                                  size:      req_i.size,
                                  is_signed: req_i.is_signed,
                                  row:       req_i.row,
                                  byte_off:  req_i.byte_off,
                                  wdata:     req_i.wdata};
        end
    end

    // byte storage, big-endian inside each word
    always_ff @(posedge clk_i) begin
        if (pop && head.op == OP_STORE) begin
            if (head.size == SIZE_BYTE) begin
                mem_q[{head.row, head.byte_off}] <= head.wdata[7:0];
            end else begin
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    mem_q[{head.row, OFF_WIDTH'(i)}] <= head.wdata[DATA_WIDTH-1-8*i -: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= pop_load;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_load) begin
            rdata_q  <= {mem_q[{head.row, 2'd0}], mem_q[{head.row, 2'd1}],
                         mem_q[{head.row, 2'd2}], mem_q[{head.row, 2'd3}]};
            size_q   <= head.size;
            signed_q <= head.is_signed;
            off_q    <= head.byte_off;
        end
    end

    assign rsp_o.valid     = rsp_valid_q;
    assign rsp_o.rdata     = rdata_q;
    assign rsp_o.size      = size_q;
    assign rsp_o.is_signed = signed_q;
    assign rsp_o.byte_off  = off_q;

endmodule

// ==== req_dispatch.sv ====
`timescale 1ns/10ps

module req_dispatch import dmem_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_valid_i,
    input  mem_op_e                   req_op_i,
    input  mem_size_e                 req_size_i,
    input  logic                      req_signed_i,
    input  logic [ADDR_WIDTH-1:0]     req_addr_i,
    input  logic [DATA_WIDTH-1:0]     req_wdata_i,
    output logic                      req_ready_o,
    bank_req_if.dispatch              bank_o [NUM_BANKS],
    output logic                      ord_push_o,
    output logic [BANK_SEL_WIDTH-1:0] ord_bank_o
);

    logic [BANK_SEL_WIDTH-1:0] sel;
    logic [ROW_WIDTH-1:0]      row;
    logic [OFF_WIDTH-1:0]      off;
    logic                      accept;
    logic [NUM_BANKS-1:0]      has_cred;
    logic [NUM_BANKS-1:0]      fire;
    logic [NUM_BANKS-1:0]      credit_in;
    logic [REQ_CNT_WIDTH-1:0]  cred_q [NUM_BANKS];

    // address split: row | bank | byte offset
    assign off = req_addr_i[OFF_WIDTH-1:0];
    assign sel = req_addr_i[OFF_WIDTH+BANK_SEL_WIDTH-1:OFF_WIDTH];
    assign row = req_addr_i[ADDR_WIDTH-1:OFF_WIDTH+BANK_SEL_WIDTH];

    assign req_ready_o = has_cred[sel];              // depends on address only, not on valid
    assign accept      = req_valid_i & req_ready_o;

    // loads are remembered so the merger can restore request order
    assign ord_push_o = accept & (req_op_i == OP_LOAD);
    assign ord_bank_o = sel;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        assign has_cred[g]  = (cred_q[g] != '0);
        assign fire[g]      = accept & (sel == BANK_SEL_WIDTH'(g));
        assign credit_in[g] = bank_o[g].credit;

        assign bank_o[g].valid     = fire[g];
        assign bank_o[g].op        = req_op_i;      // payload is broadcast, valid picks the bank
        assign bank_o[g].size      = req_size_i;
        assign bank_o[g].is_signed = req_signed_i;
        assign bank_o[g].row       = row;
        assign bank_o[g].byte_off  = off;
        assign bank_o[g].wdata     = req_wdata_i;

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                cred_q[g] <= REQ_CNT_WIDTH'(REQ_CREDITS);
            end else begin
                case ({credit_in[g], fire[g]})
                    2'b10:   cred_q[g] <= cred_q[g] + 1'b1;
                    2'b01:   cred_q[g] <= cred_q[g] - 1'b1;
                    default: cred_q[g] <= cred_q[g];   // both or neither cancel out
                endcase
            end
        end
    end

endmodule

// ==== rsp_merge.sv ====
`timescale 1ns/10ps

module rsp_merge import dmem_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    bank_rsp_if.merge                 rsp_i [NUM_BANKS],
    input  logic                      ord_push_i,
    input  logic [BANK_SEL_WIDTH-1:0] ord_bank_i,
    output logic                      rsp_valid_o,
    output logic [DATA_WIDTH-1:0]     rsp_rdata_o,
    input  logic                      rsp_ready_i
);

    logic [BANK_SEL_WIDTH-1:0] ord_q [ORDER_DEPTH];
    logic [ORD_PTR_WIDTH-1:0]  ord_wr_q;
    logic [ORD_PTR_WIDTH-1:0]  ord_rd_q;
    logic [ORD_CNT_WIDTH-1:0]  ord_cnt_q;
    logic [BANK_SEL_WIDTH-1:0] head_bank;

    logic [NUM_BANKS-1:0]      buf_valid;
    logic [NUM_BANKS-1:0]      buf_pop;
    logic [DATA_WIDTH-1:0]     head_rdata  [NUM_BANKS];
    mem_size_e                 head_size   [NUM_BANKS];
    logic                      head_signed [NUM_BANKS];
    logic [OFF_WIDTH-1:0]      head_off    [NUM_BANKS];

    logic                      out_free;
    logic                      pop;
    logic [DATA_WIDTH-1:0]     fmt_data;
    logic                      rsp_valid_q;
    logic [DATA_WIDTH-1:0]     rsp_rdata_q;

    assign head_bank = ord_q[ord_rd_q];
    assign out_free  = ~rsp_valid_q | rsp_ready_i;
    assign pop       = out_free & (ord_cnt_q != '0) & buf_valid[head_bank];

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_buf
        logic [DATA_WIDTH-1:0]    data_q   [RSP_CREDITS];
        mem_size_e                size_q   [RSP_CREDITS];
        logic                     signed_q [RSP_CREDITS];
        logic [OFF_WIDTH-1:0]     off_q    [RSP_CREDITS];
        logic [RSP_PTR_WIDTH-1:0] wr_q;
        logic [RSP_PTR_WIDTH-1:0] rd_q;
        logic [RSP_CNT_WIDTH-1:0] cnt_q;

        assign buf_pop[g]     = pop & (head_bank == BANK_SEL_WIDTH'(g));
        assign buf_valid[g]   = (cnt_q != '0);
        assign head_rdata[g]  = data_q[rd_q];
        assign head_size[g]   = size_q[rd_q];
        assign head_signed[g] = signed_q[rd_q];
        assign head_off[g]    = off_q[rd_q];
        assign rsp_i[g].credit = buf_pop[g];       // entry freed, bank may send again

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                wr_q  <= '0;
                rd_q  <= '0;
                cnt_q <= '0;
            end else begin
                if (rsp_i[g].valid) wr_q <= wr_q + 1'b1;
                if (buf_pop[g])     rd_q <= rd_q + 1'b1;
                case ({rsp_i[g].valid, buf_pop[g]})
                    2'b10:   cnt_q <= cnt_q + 1'b1;
                    2'b01:   cnt_q <= cnt_q - 1'b1;
                    default: cnt_q <= cnt_q;
                endcase
            end
        end

        always_ff @(posedge clk_i) begin
            if (rsp_i[g].valid) begin
                data_q[wr_q]   <= rsp_i[g].rdata;
                size_q[wr_q]   <= rsp_i[g].size;
                signed_q[wr_q] <= rsp_i[g].is_signed;
                off_q[wr_q]    <= rsp_i[g].byte_off;
            end
        end
    end

    // order FIFO is not a power of two deep, so pointers wrap by hand
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ord_wr_q  <= '0;
            ord_rd_q  <= '0;
            ord_cnt_q <= '0;
        end else begin
            if (ord_push_i) begin
                ord_wr_q <= (ord_wr_q == ORD_PTR_WIDTH'(ORDER_DEPTH - 1)) ? '0 : ord_wr_q + 1'b1;
            end
            if (pop) begin
                ord_rd_q <= (ord_rd_q == ORD_PTR_WIDTH'(ORDER_DEPTH - 1)) ? '0 : ord_rd_q + 1'b1;
            end
            case ({ord_push_i, pop})
                2'b10:   ord_cnt_q <= ord_cnt_q + 1'b1;
                2'b01:   ord_cnt_q <= ord_cnt_q - 1'b1;
                default: ord_cnt_q <= ord_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ord_push_i) ord_q[ord_wr_q] <= ord_bank_i;
    end

    always_comb begin
        if (head_size[head_bank] == SIZE_BYTE) begin
            fmt_data = ext_byte(sel_byte(head_rdata[head_bank], head_off[head_bank]),
                                head_signed[head_bank]);
        end else begin
            fmt_data = head_rdata[head_bank];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (pop) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;                   // taken with nothing behind it
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) rsp_rdata_q <= fmt_data;          // held stable until taken
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dmem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -f verilog.f --top-module dmem_tb -o dmem_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "build failed"
    exit 1
fi

./obj_dir/dmem_sim 2>&1 | tee "$sim_log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "=== FAIL ===" "$sim_log"; then
    exit 1
fi
exit 0

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;          // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_n_o = 1'b1;                  // released just after the second edge
    end

endmodule

// ==== verilog.f ====
dmem_pkg.sv
bank_req_if.sv
bank_rsp_if.sv
req_dispatch.sv
mem_bank.sv
rsp_merge.sv
dmem_top.sv
tb_clock_gen.sv
dmem_checker.sv
dmem_tb.sv
